// ==== src/krz_settings.svh ====
// Address width, region selects, memory depth and system register offsets
`ifndef KRZ_SETTINGS_SVH
`define KRZ_SETTINGS_SVH

// Byte address width seen by both ports
`define KRZ_ADDR_W 24

// Words per data memory; upper index bits alias inside a region
`define KRZ_MEM_WORDS 1024

// ====================
// Region select values for address bits 23 to 16
// ====================
`define KRZ_MEM0_BASE 8'h00
`define KRZ_MEM1_BASE 8'h01
`define KRZ_SYS_BASE 8'h80

// ====================
// System register word offsets
// ====================
`define KRZ_SYS_LEDR 6'd0
`define KRZ_SYS_LEDG 6'd1

`endif

// ==== src/krz_map_pkg.sv ====
// Address map types: target region and system register select
`default_nettype none

`include "krz_settings.svh"

package krz_map_pkg;

    // Target of a decoded address
    typedef enum logic [1:0] {
        REG_MEM0,
        REG_MEM1,
        REG_SYS,
        REG_NONE
    } region_e;

    // System register, from address bits 7 to 2
    typedef enum logic [5:0] {
        SYS_LEDR = `KRZ_SYS_LEDR,
        SYS_LEDG = `KRZ_SYS_LEDG
    } sys_reg_e;

endpackage

`default_nettype wire

// ==== src/krz_bus_pkg.sv ====
// Bus transaction types: port request and response, bank command, port state
`default_nettype none

`include "krz_settings.svh"

package krz_bus_pkg;
    import krz_map_pkg::*;

    // Word index width, byte offset dropped
    localparam int WIDX_W = `KRZ_ADDR_W - 2;

    // One port's pending access after decode
    typedef struct packed {
        logic              valid;
        region_e           region;
        logic [WIDX_W-1:0] idx;
        logic              wr_en;
        logic [3:0]        wr_mask;
        logic [31:0]       wr_data;
    } port_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rd_data;
    } port_rsp_t;

    // Command seen by one target
    typedef struct packed {
        logic              en;
        logic              wr_en;
        logic [3:0]        wr_mask;
        logic [WIDX_W-1:0] idx;
        logic [31:0]       wr_data;
    } bank_cmd_t;

    typedef enum logic {
        PS_IDLE,
        PS_ACKED
    } port_state_e;

endpackage

`default_nettype wire

// ==== src/krz_port_front.sv ====
// Port front: region decode and request tracking up to acknowledge
`timescale 1ns/1ps
`default_nettype none

`include "krz_settings.svh"

module krz_port_front (
    input  logic                   clk,
    input  logic                   RSTN,
    input  logic [`KRZ_ADDR_W-1:0] addr_i,
    input  logic                   req_i,
    input  logic                   wr_en_i,
    input  logic [3:0]             wr_mask_i,
    input  logic [31:0]            wr_data_i,
    input  logic                   grant_i,
    input  krz_bus_pkg::port_rsp_t rsp_i,
    output krz_bus_pkg::port_req_t req_o,
    output logic                   ack_o,
    output logic [31:0]            rd_data_o
);
    import krz_map_pkg::*;
    import krz_bus_pkg::*;

    port_state_e state;
    region_e     region;

    // Upper byte of the address picks the target
    always_comb begin
        case (addr_i[`KRZ_ADDR_W-1 -: 8])
            `KRZ_MEM0_BASE: region = REG_MEM0;
            `KRZ_MEM1_BASE: region = REG_MEM1;
            `KRZ_SYS_BASE:  region = REG_SYS;
            default:        region = REG_NONE;
        endcase
    end

    // Request is hidden during the ack cycle while the master still holds req
    assign req_o.valid   = req_i && (state == PS_IDLE);
    assign req_o.region  = region;
    assign req_o.idx     = addr_i[`KRZ_ADDR_W-1:2];
    assign req_o.wr_en   = wr_en_i;
    assign req_o.wr_mask = wr_mask_i;
    assign req_o.wr_data = wr_data_i;

    always_ff @(posedge clk or negedge RSTN) begin
        if (!RSTN) begin
            state <= PS_IDLE;
        end else begin
            case (state)
                PS_IDLE:  if (grant_i) state <= PS_ACKED;
                PS_ACKED: state <= PS_IDLE;
                default:  state <= PS_IDLE;
            endcase
        end
    end

    assign ack_o     = rsp_i.ack;
    assign rd_data_o = rsp_i.rd_data;

endmodule

`default_nettype wire

// ==== src/krz_bank_arbiter.sv ====
// Bank arbiter: per-target grant with data priority, bank commands, read return
`timescale 1ns/1ps
`default_nettype none

module krz_bank_arbiter (
    input  logic                   clk,
    input  logic                   RSTN,
    input  krz_bus_pkg::port_req_t ireq_i,
    input  krz_bus_pkg::port_req_t dreq_i,
    output logic                   igrant_o,
    output logic                   dgrant_o,
    output krz_bus_pkg::port_rsp_t irsp_o,
    output krz_bus_pkg::port_rsp_t drsp_o,
    output krz_bus_pkg::bank_cmd_t mem0_cmd_o,
    output krz_bus_pkg::bank_cmd_t mem1_cmd_o,
    output krz_bus_pkg::bank_cmd_t sys_cmd_o,
    input  logic [31:0]            mem0_rd_i,
    input  logic [31:0]            mem1_rd_i,
    input  logic [31:0]            sys_rd_i
);
    import krz_map_pkg::*;
    import krz_bus_pkg::*;

    region_e i_region;
    logic    i_blocked;
    region_e i_sel_q;
    region_e d_sel_q;
    logic    i_ack_q;
    logic    d_ack_q;

    function automatic bank_cmd_t to_cmd(port_req_t r, logic allow_wr);
        bank_cmd_t c;
        c.en      = 1'b1;
        c.wr_en   = r.wr_en & allow_wr;
        c.wr_mask = r.wr_mask;
        c.idx     = r.idx;
        c.wr_data = r.wr_data;
        return c;
    endfunction

    function automatic logic [31:0] rd_mux(region_e sel, logic [31:0] m0, logic [31:0] m1,
                                           logic [31:0] sy);
        case (sel)
            REG_MEM0: return m0;
            REG_MEM1: return m1;
            REG_SYS:  return sy;
            default:  return 32'h0;
        endcase
    endfunction

    // ====================
    // Grant
    // ====================
    // Fetches from the system block are answered like unmapped ones
    assign i_region = (ireq_i.region == REG_SYS) ? REG_NONE : ireq_i.region;

    // Unmapped requests never collide
    assign i_blocked = dreq_i.valid && (dreq_i.region == i_region) && (i_region != REG_NONE);
    assign dgrant_o  = dreq_i.valid;
    assign igrant_o  = ireq_i.valid && !i_blocked;

    always_comb begin
        mem0_cmd_o = '0;
        mem1_cmd_o = '0;
        sys_cmd_o  = '0;
        if (igrant_o) begin
            case (i_region)
                REG_MEM0: mem0_cmd_o = to_cmd(ireq_i, 1'b0);
                REG_MEM1: mem1_cmd_o = to_cmd(ireq_i, 1'b0);
                default:  ;
            endcase
        end
        if (dgrant_o) begin
            case (dreq_i.region)
                REG_MEM0: mem0_cmd_o = to_cmd(dreq_i, 1'b1);
                REG_MEM1: mem1_cmd_o = to_cmd(dreq_i, 1'b1);
                REG_SYS:  sys_cmd_o  = to_cmd(dreq_i, 1'b1);
                default:  ;
            endcase
        end
    end

    // ====================
    // Response
    // ====================
    always_ff @(posedge clk or negedge RSTN) begin
        if (!RSTN) begin
            i_ack_q <= 1'b0;
            d_ack_q <= 1'b0;
            i_sel_q <= REG_NONE;
            d_sel_q <= REG_NONE;
        end else begin
            i_ack_q <= igrant_o;
            d_ack_q <= dgrant_o;
            i_sel_q <= i_region;
            d_sel_q <= dreq_i.region;
        end
    end

    // Targets hold last cycle's read word, so the mux is combinational
    assign irsp_o.ack     = i_ack_q;
    assign irsp_o.rd_data = rd_mux(i_sel_q, mem0_rd_i, mem1_rd_i, sys_rd_i);
    assign drsp_o.ack     = d_ack_q;
    assign drsp_o.rd_data = rd_mux(d_sel_q, mem0_rd_i, mem1_rd_i, sys_rd_i);

endmodule

`default_nettype wire

// ==== src/krz_sram.sv ====
// Word memory with byte-masked writes and a registered read port
`timescale 1ns/1ps
`default_nettype none

`include "krz_settings.svh"

module krz_sram (
    input  logic                   clk,
    input  krz_bus_pkg::bank_cmd_t cmd_i,
    output logic [31:0]            rd_data_o
);
    localparam int IDX_W = $clog2(`KRZ_MEM_WORDS);

    logic [31:0]      mem [`KRZ_MEM_WORDS];
    logic [IDX_W-1:0] widx;

    // Upper index bits alias
    assign widx = cmd_i.idx[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (cmd_i.en) begin
            if (cmd_i.wr_en) begin
                for (int b = 0; b < 4; b++) begin
                    if (cmd_i.wr_mask[b]) begin
                        mem[widx][8*b +: 8] <= cmd_i.wr_data[8*b +: 8];
                    end
                end
            end
            // Read-first, returns the word before this write
            rd_data_o <= mem[widx];
        end
    end

endmodule

`default_nettype wire

// ==== src/krz_sysctrl.sv ====
// System block: LED registers, readback and active-low LED pins
`timescale 1ns/1ps
`default_nettype none

module krz_sysctrl (
    input  logic                   clk,
    input  logic                   RSTN,
    input  krz_bus_pkg::bank_cmd_t cmd_i,
    output logic [31:0]            rd_data_o,
    output logic                   ledr_o,
    output logic                   ledg_o
);
    import krz_map_pkg::*;

    sys_reg_e sel;
    logic     ledr_q;
    logic     ledg_q;

    // Word offset within the region, address bits 7 to 2
    assign sel = sys_reg_e'(cmd_i.idx[5:0]);

    always_ff @(posedge clk or negedge RSTN) begin
        if (!RSTN) begin
            ledr_q <= 1'b0;
            ledg_q <= 1'b0;
        end else if (cmd_i.en && cmd_i.wr_en) begin
            case (sel)
                SYS_LEDR: ledr_q <= cmd_i.wr_data[0];
                SYS_LEDG: ledg_q <= cmd_i.wr_data[0];
                default:  ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_i.en) begin
            case (sel)
                SYS_LEDR: rd_data_o <= {31'b0, ledr_q};
                SYS_LEDG: rd_data_o <= {31'b0, ledg_q};
                default:  rd_data_o <= 32'h0;
            endcase
        end
    end

    // Board LEDs light on a low pin
    assign ledr_o = ~ledr_q;
    assign ledg_o = ~ledg_q;

endmodule

`default_nettype wire

// ==== src/krz_soc_top.sv ====
// Top level: instruction and data fronts, bank arbiter, two memories, system block
`timescale 1ns/1ps
`default_nettype none

`include "krz_settings.svh"

module krz_soc_top (
    input  logic                   clk,
    input  logic                   RSTN,
    input  logic [`KRZ_ADDR_W-1:0] instr_addr_i,
    input  logic                   instr_req_i,
    output logic                   instr_ack_o,
    output logic [31:0]            instr_data_o,
    input  logic [`KRZ_ADDR_W-1:0] data_addr_i,
    input  logic [31:0]            data_wr_data_i,
    input  logic [3:0]             data_wr_mask_i,
    input  logic                   data_wr_en_i,
    input  logic                   data_req_i,
    output logic                   data_ack_o,
    output logic [31:0]            data_rd_data_o,
    output logic                   ledr_o,
    output logic                   ledg_o
);
    import krz_bus_pkg::*;

    port_req_t   ireq;
    port_req_t   dreq;
    port_rsp_t   irsp;
    port_rsp_t   drsp;
    logic        igrant;
    logic        dgrant;
    bank_cmd_t   mem0_cmd;
    bank_cmd_t   mem1_cmd;
    bank_cmd_t   sys_cmd;
    logic [31:0] mem0_rd;
    logic [31:0] mem1_rd;
    logic [31:0] sys_rd;

    // ====================
    // Port fronts
    // ====================
    // Fetch port is read-only
    krz_port_front u_ifront (
        .clk(clk), .RSTN(RSTN),
        .addr_i(instr_addr_i), .req_i(instr_req_i),
        .wr_en_i(1'b0), .wr_mask_i(4'h0), .wr_data_i(32'h0),
        .grant_i(igrant), .rsp_i(irsp), .req_o(ireq),
        .ack_o(instr_ack_o), .rd_data_o(instr_data_o)
    );

    krz_port_front u_dfront (
        .clk(clk), .RSTN(RSTN),
        .addr_i(data_addr_i), .req_i(data_req_i),
        .wr_en_i(data_wr_en_i), .wr_mask_i(data_wr_mask_i), .wr_data_i(data_wr_data_i),
        .grant_i(dgrant), .rsp_i(drsp), .req_o(dreq),
        .ack_o(data_ack_o), .rd_data_o(data_rd_data_o)
    );

    // ====================
    // Arbiter and targets
    // ====================
    krz_bank_arbiter u_arbiter (
        .clk(clk), .RSTN(RSTN),
        .ireq_i(ireq), .dreq_i(dreq), .igrant_o(igrant), .dgrant_o(dgrant),
        .irsp_o(irsp), .drsp_o(drsp),
        .mem0_cmd_o(mem0_cmd), .mem1_cmd_o(mem1_cmd), .sys_cmd_o(sys_cmd),
        .mem0_rd_i(mem0_rd), .mem1_rd_i(mem1_rd), .sys_rd_i(sys_rd)
    );

    krz_sram u_mem0 (.clk(clk), .cmd_i(mem0_cmd), .rd_data_o(mem0_rd));
    krz_sram u_mem1 (.clk(clk), .cmd_i(mem1_cmd), .rd_data_o(mem1_rd));

    krz_sysctrl u_sysctrl (
        .clk(clk), .RSTN(RSTN), .cmd_i(sys_cmd), .rd_data_o(sys_rd),
        .ledr_o(ledr_o), .ledg_o(ledg_o)
    );

endmodule

`default_nettype wire

// ==== verif/krz_soc_assertions.sv ====
// Bus-protocol assertions for the SoC top level, and their bind
`timescale 1ns/1ps
`default_nettype none

module krz_soc_assertions (
    input wire logic clk,
    input wire logic RSTN,
    input wire logic instr_req_i,
    input wire logic instr_ack_i,
    input wire logic data_req_i,
    input wire logic data_ack_i,
    input wire logic ledr_i,
    input wire logic ledg_i
);

    // ====================
    // Ack pulses
    // ====================
    a_instr_ack_pulse: assert property (@(posedge clk) disable iff (!RSTN)
        instr_ack_i |=> !instr_ack_i)
        else $error("Instruction ack stayed high for two cycles");

    a_data_ack_pulse: assert property (@(posedge clk) disable iff (!RSTN)
        data_ack_i |=> !data_ack_i)
        else $error("Data ack stayed high for two cycles");

    // An ack answers a request from the cycle before
    a_instr_ack_req: assert property (@(posedge clk) disable iff (!RSTN)
        instr_ack_i |-> $past(instr_req_i))
        else $error("Instruction ack without a request in the previous cycle");

    a_data_ack_req: assert property (@(posedge clk) disable iff (!RSTN)
        data_ack_i |-> $past(data_req_i))
        else $error("Data ack without a request in the previous cycle");

    // LEDs dark in reset, pins high
    a_leds_reset: assert property (@(posedge clk) !RSTN |-> (ledr_i && ledg_i))
        else $error("LED pins not both high during reset");

endmodule

bind krz_soc_top krz_soc_assertions i_krz_soc_assertions (
    .clk(clk), .RSTN(RSTN),
    .instr_req_i(instr_req_i), .instr_ack_i(instr_ack_o),
    .data_req_i(data_req_i), .data_ack_i(data_ack_o),
    .ledr_i(ledr_o), .ledg_i(ledg_o)
);

`default_nettype wire

// ==== verif/krz_soc_tb.sv ====
// SoC bus testbench with clock, reset, LFSR, reference model, directed tests and timeout
`timescale 1ns/1ps
`default_nettype none

`include "krz_settings.svh"

module krz_soc_tb;
    localparam int IDX_W = $clog2(`KRZ_MEM_WORDS);
    localparam int RESET_CYCLES = 10;
    // Accesses per test in run order
    localparam int ACCESSES = 8 + 5 + 9 + 7 + 10 + 80;
    // Contention costs at most one extra cycle per access
    localparam int TEST_CYCLES = RESET_CYCLES + 1 + 3 * ACCESSES;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                   clk;
    logic                   RSTN;
    logic [`KRZ_ADDR_W-1:0] instr_addr;
    logic                   instr_req;
    logic                   instr_ack;
    logic [31:0]            instr_data;
    logic [`KRZ_ADDR_W-1:0] data_addr;
    logic [31:0]            data_wr_data;
    logic [3:0]             data_wr_mask;
    logic                   data_wr_en;
    logic                   data_req;
    logic                   data_ack;
    logic [31:0]            data_rd_data;
    logic                   ledr;
    logic                   ledg;

    // Reference model state
    logic [31:0] model0 [`KRZ_MEM_WORDS];
    logic [31:0] model1 [`KRZ_MEM_WORDS];
    logic        known0 [`KRZ_MEM_WORDS];
    logic        known1 [`KRZ_MEM_WORDS];
    logic        ledr_m;
    logic        ledg_m;
    logic [31:0] lfsr_q;
    int          checks = 0;
    int          errors = 0;
    int          cycle_cnt = 0;

    krz_soc_top i_krz_soc_top (
        .clk(clk), .RSTN(RSTN),
        .instr_addr_i(instr_addr), .instr_req_i(instr_req),
        .instr_ack_o(instr_ack), .instr_data_o(instr_data),
        .data_addr_i(data_addr), .data_wr_data_i(data_wr_data),
        .data_wr_mask_i(data_wr_mask), .data_wr_en_i(data_wr_en),
        .data_req_i(data_req), .data_ack_o(data_ack), .data_rd_data_o(data_rd_data),
        .ledr_o(ledr), .ledg_o(ledg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, an access never got its ack", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    // ====================
    // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
    // ====================
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // ====================
    // Reference model of the address map
    // ====================
    function automatic logic [31:0] model_read(logic [`KRZ_ADDR_W-1:0] addr, logic fetch);
        logic [IDX_W-1:0] w;
        w = addr[IDX_W+1:2];
        case (addr[`KRZ_ADDR_W-1 -: 8])
            `KRZ_MEM0_BASE: return model0[w];
            `KRZ_MEM1_BASE: return model1[w];
            `KRZ_SYS_BASE: begin
                // Fetch port sees the system region as unmapped
                if (fetch) return 32'h0;
                if (addr[7:2] == `KRZ_SYS_LEDR) return {31'b0, ledr_m};
                if (addr[7:2] == `KRZ_SYS_LEDG) return {31'b0, ledg_m};
                return 32'h0;
            end
            default: return 32'h0;
        endcase
    endfunction

    function automatic void model_write(logic [`KRZ_ADDR_W-1:0] addr, logic [3:0] mask,
                                        logic [31:0] d);
        logic [IDX_W-1:0] w;
        logic [7:0]       sel;
        w = addr[IDX_W+1:2];
        sel = addr[`KRZ_ADDR_W-1 -: 8];
        for (int b = 0; b < 4; b++) begin
            if (mask[b] && sel == `KRZ_MEM0_BASE) model0[w][8*b +: 8] = d[8*b +: 8];
            if (mask[b] && sel == `KRZ_MEM1_BASE) model1[w][8*b +: 8] = d[8*b +: 8];
        end
        if (sel == `KRZ_MEM0_BASE) known0[w] = known0[w] | (mask == 4'hf);
        if (sel == `KRZ_MEM1_BASE) known1[w] = known1[w] | (mask == 4'hf);
        // LED registers keep bit 0 only
        if (sel == `KRZ_SYS_BASE && addr[7:2] == `KRZ_SYS_LEDR) ledr_m = d[0];
        if (sel == `KRZ_SYS_BASE && addr[7:2] == `KRZ_SYS_LEDG) ledg_m = d[0];
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_led(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic leds_match();
        check_led("ledr_o", ledr, ~ledr_m);
        check_led("ledg_o", ledg, ~ledg_m);
    endtask

    // ====================
    // Port accesses entered 1 ns after a rising edge
    // ====================
    task automatic data_access(input logic [`KRZ_ADDR_W-1:0] addr, input logic wr,
                               input logic [3:0] mask, input logic [31:0] wdata,
                               output logic [31:0] rdata, output int lat);
        data_addr = addr;
        data_wr_en = wr;
        data_wr_mask = mask;
        data_wr_data = wdata;
        data_req = 1'b1;
        lat = 0;
        @(negedge clk);
        while (!data_ack) begin
            lat++;
            @(negedge clk);
        end
        rdata = data_rd_data;
        @(posedge clk);
        #1;
        data_req = 1'b0;
        data_wr_en = 1'b0;
    endtask

    task automatic fetch(input logic [`KRZ_ADDR_W-1:0] addr, output logic [31:0] rdata,
                         output int lat);
        instr_addr = addr;
        instr_req = 1'b1;
        lat = 0;
        @(negedge clk);
        while (!instr_ack) begin
            lat++;
            @(negedge clk);
        end
        rdata = instr_data;
        @(posedge clk);
        #1;
        instr_req = 1'b0;
    endtask

    task automatic dwrite(logic [`KRZ_ADDR_W-1:0] addr, logic [3:0] mask, logic [31:0] d);
        logic [31:0] rd;
        int          lat;
        data_access(addr, 1'b1, mask, d, rd, lat);
        model_write(addr, mask, d);
    endtask

    task automatic dread(logic [`KRZ_ADDR_W-1:0] addr);
        logic [31:0] rd;
        int          lat;
        data_access(addr, 1'b0, 4'h0, 32'h0, rd, lat);
        check_word($sformatf("data_rd_data_o @%h", addr), rd, model_read(addr, 1'b0));
    endtask

    task automatic ifetch(logic [`KRZ_ADDR_W-1:0] addr);
        logic [31:0] rd;
        int          lat;
        fetch(addr, rd, lat);
        check_word($sformatf("instr_data_o @%h", addr), rd, model_read(addr, 1'b1));
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_masked_writes();
        dwrite(24'h00_0010, 4'hf, 32'h1122_3344);
        dwrite(24'h00_0010, 4'h5, 32'haabb_ccdd);
        dwrite(24'h01_0010, 4'hf, 32'h5566_7788);
        dwrite(24'h01_0010, 4'h8, 32'hee00_0000);
        dwrite(24'h00_0014, 4'hf, 32'hcafe_f00d);
        dread(24'h00_0010);
        dread(24'h01_0010);
        dread(24'h00_0014);
    endtask

    task automatic test_fetch_after_write();
        dwrite(24'h00_0100, 4'hf, 32'h0000_0513);
        dwrite(24'h01_0200, 4'hf, 32'h00a5_0593);
        ifetch(24'h00_0100);
        ifetch(24'h01_0200);
        ifetch(24'h00_0010);
    endtask

    task automatic test_leds();
        leds_match();
        dwrite(24'h80_0000, 4'hf, 32'h1);
        leds_match();
        dread(24'h80_0000);
        dwrite(24'h80_0004, 4'hf, 32'h1);
        leds_match();
        dread(24'h80_0004);
        dwrite(24'h80_0000, 4'hf, 32'h0);
        leds_match();
        dread(24'h80_0000);
        // Upper data bits set but bit 0 clear
        dwrite(24'h80_0004, 4'hf, 32'hffff_fffe);
        leds_match();
        dread(24'h80_0004);
        // Offsets past LEDG read zero
        dread(24'h80_0008);
    endtask

    task automatic test_concurrent();
        logic [31:0] ird;
        logic [31:0] drd;
        int          ilat;
        int          dlat;
        // Different targets served in the same cycle
        fork
            data_access(24'h01_0010, 1'b0, 4'h0, 32'h0, drd, dlat);
            fetch(24'h00_0010, ird, ilat);
        join
        check_word("data_rd_data_o", drd, model_read(24'h01_0010, 1'b0));
        check_word("instr_data_o", ird, model_read(24'h00_0010, 1'b1));
        check_count("data ack latency", dlat, 1);
        check_count("instr ack latency", ilat, 1);
        fork
            data_access(24'h01_0020, 1'b1, 4'hf, 32'h0bad_beef, drd, dlat);
            fetch(24'h00_0100, ird, ilat);
        join
        model_write(24'h01_0020, 4'hf, 32'h0bad_beef);
        check_word("instr_data_o", ird, model_read(24'h00_0100, 1'b1));
        check_count("data ack latency", dlat, 1);
        check_count("instr ack latency", ilat, 1);
        dread(24'h01_0020);
        // Same target where the fetch loses one grant
        fork
            data_access(24'h00_0010, 1'b0, 4'h0, 32'h0, drd, dlat);
            fetch(24'h00_0100, ird, ilat);
        join
        check_word("data_rd_data_o", drd, model_read(24'h00_0010, 1'b0));
        check_word("instr_data_o", ird, model_read(24'h00_0100, 1'b1));
        check_count("data ack latency", dlat, 1);
        check_count("instr ack latency", ilat, 2);
    endtask

    task automatic test_unmapped();
        // LEDG set so the system fetch has a nonzero word to miss
        dwrite(24'h80_0004, 4'hf, 32'h1);
        dwrite(24'h02_0010, 4'hf, 32'hffff_ffff);
        dwrite(24'h81_0000, 4'hf, 32'h1);
        dread(24'h02_0010);
        dread(24'hff_fffc);
        dread(24'h00_0010);
        dread(24'h01_0010);
        // Reads zero although LEDG holds 1
        ifetch(24'h80_0004);
        ifetch(24'h40_0000);
        dread(24'h80_0004);
        leds_match();
    endtask

    task automatic test_random();
        logic [31:0]            r;
        logic [IDX_W-1:0]       w;
        logic [`KRZ_ADDR_W-1:0] addr;
        logic [3:0]             mask;
        logic                   known;
        for (int n = 0; n < 40; n++) begin
            r = rand_bits(IDX_W);
            w = r[IDX_W-1:0];
            r = rand_bits(1);
            addr = '0;
            addr[`KRZ_ADDR_W-1 -: 8] = r[0] ? `KRZ_MEM1_BASE : `KRZ_MEM0_BASE;
            addr[IDX_W+1:2] = w;
            known = r[0] ? known1[w] : known0[w];
            r = rand_bits(4);
            // First write to a word fills all bytes
            mask = known ? r[3:0] : 4'hf;
            dwrite(addr, mask, rand_bits(32));
            dread(addr);
        end
    endtask

    initial begin
        RSTN = 1'b0;
        instr_addr = '0;
        instr_req = 1'b0;
        data_addr = '0;
        data_wr_data = '0;
        data_wr_mask = '0;
        data_wr_en = 1'b0;
        data_req = 1'b0;
        ledr_m = 1'b0;
        ledg_m = 1'b0;
        lfsr_q = 32'hc543dc87;
        for (int i = 0; i < `KRZ_MEM_WORDS; i++) begin
            known0[i] = 1'b0;
            known1[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        RSTN = 1'b1;
        @(posedge clk);
        #1;
        test_masked_writes();
        test_fetch_after_write();
        test_leds();
        test_concurrent();
        test_unmapped();
        test_random();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/krz_map_pkg.sv
src/krz_bus_pkg.sv
src/krz_port_front.sv
src/krz_bank_arbiter.sv
src/krz_sram.sv
src/krz_sysctrl.sv
src/krz_soc_top.sv
verif/krz_soc_assertions.sv
verif/krz_soc_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = krz_soc_tb
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then exit 1; fi
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
